/* src/mem_bank_array.sv */
// Byte-lane memory banks
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_bank_array
  import mem_pkg::*;
(
  input  logic          mem_clk,
  // Access command from the request stage
  input  mem_bank_cmd_t bank_cmd,
  // Word read on the last access, held until the next one
  output mem_data_u     bank_rdata
);

  localparam int NUM_WORDS = 1 << `MEM_WORD_ADDR_BITS;

  // Per-lane read registers
  logic [7:0] rd_q [4];

  // --------------------------------------------------------------------
  // Banks
  // --------------------------------------------------------------------

  // One byte-wide bank per lane
  // Read is old data, the write lands at the same edge
  for (genvar i = 0; i < 4; i++) begin : g_lane
    logic [7:0] mem [NUM_WORDS];

    always_ff @(posedge mem_clk) begin
      if (bank_cmd.rd_en) begin
        // Old byte first
        rd_q[i] <= mem[bank_cmd.word_addr];
        if (bank_cmd.wr_mask[i]) begin
          mem[bank_cmd.word_addr] <= bank_cmd.wdata.lane[i];
        end
      end
      // No access, read register keeps the last word for a stalled response
    end
  end

  // --------------------------------------------------------------------
  // Read word
  // --------------------------------------------------------------------

  // Lanes back into one word
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      bank_rdata.lane[i] = rd_q[i];
    end
  end

endmodule

/* src/mem_cfg.svh */
// Memory server configuration
`ifndef MEM_CFG_SVH
`define MEM_CFG_SVH

// --------------------------------------------------------------------
// Storage geometry
// --------------------------------------------------------------------

// Word address width
// 10 bits gives 1024 words, 4 KB in total
// Byte address bits [1:0] select a lane and are not used here
// Bits at or above 2 + this width are dropped, so high addresses alias
`define MEM_WORD_ADDR_BITS 10

// --------------------------------------------------------------------
// Message fields
// --------------------------------------------------------------------

// Opaque tag width
// Carried through untouched from request to response
`define MEM_OPAQUE_BITS 8

`endif

/* src/mem_pkg.sv */
// Memory server message types
`include "mem_cfg.svh"

package mem_pkg;

  // ------------------------------------------------------------------
  // Operation and data word
  // ------------------------------------------------------------------

  // Single bit op code
  typedef enum logic {
    MEM_OP_READ  = 1'b0,
    MEM_OP_WRITE = 1'b1
  } mem_op_e;

  // One 32-bit word, seen whole or as four byte lanes
  // Lane 0 is the least significant byte, one lane per bank
  typedef union packed {
    logic [31:0]     word;
    logic [3:0][7:0] lane;
  } mem_data_u;

  // ------------------------------------------------------------------
  // Messages
  // ------------------------------------------------------------------

  // Request from the client
  typedef struct packed {
    mem_op_e                     op;
    logic [`MEM_OPAQUE_BITS-1:0] opaque;
    logic [1:0]                  origin;
    logic [31:0]                 addr;
    logic [3:0]                  byte_mask;
    mem_data_u                   data;
  } mem_req_t;

  // Response to the client, data holds the word as read
  typedef struct packed {
    mem_op_e                     op;
    logic [`MEM_OPAQUE_BITS-1:0] opaque;
    logic [1:0]                  origin;
    logic [31:0]                 addr;
    logic [3:0]                  byte_mask;
    mem_data_u                   data;
  } mem_resp_t;

  // Metadata carried from the request stage to the response stage
  typedef struct packed {
    mem_op_e                     op;
    logic [`MEM_OPAQUE_BITS-1:0] opaque;
    logic [1:0]                  origin;
    logic [31:0]                 addr;
    logic [3:0]                  byte_mask;
  } mem_meta_t;

  // Command to the bank array
  typedef struct packed {
    logic                           rd_en;
    logic [3:0]                     wr_mask;
    logic [`MEM_WORD_ADDR_BITS-1:0] word_addr;
    mem_data_u                      wdata;
  } mem_bank_cmd_t;

endpackage

/* src/mem_req_stage.sv */
// Memory server request stage
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_req_stage
  import mem_pkg::*;
(
  input  logic          mem_clk,
  input  logic          rst,
  // Client request handshake
  input  logic          req_val,
  output logic          req_rdy,
  input  mem_req_t      req,
  // Read/write handoff to the response stage
  output logic          rw_val,
  input  logic          rw_rdy,
  output mem_meta_t     rw_meta,
  // Bank array command
  output mem_bank_cmd_t bank_cmd
);

  logic       valid_q;
  mem_req_t   req_q;
  logic       req_xfer;
  logic       rw_xfer;
  logic [3:0] wr_mask;

  // --------------------------------------------------------------------
  // Handshakes
  // --------------------------------------------------------------------

  assign req_xfer = req_val & req_rdy;
  assign rw_xfer  = valid_q & rw_rdy;

  // Open when empty, or when the held request leaves this cycle
  assign req_rdy = !valid_q | rw_rdy;
  assign rw_val  = valid_q;

  // --------------------------------------------------------------------
  // Read/write step register
  // --------------------------------------------------------------------

  // Valid bit, a new request wins over a drain
  always_ff @(posedge mem_clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (req_xfer) begin
      valid_q <= 1'b1;
    end else if (rw_xfer) begin
      valid_q <= 1'b0;
    end
  end

  // Payload
  always_ff @(posedge mem_clk) begin
    if (req_xfer) begin
      req_q <= req;
    end
  end

  // --------------------------------------------------------------------
  // Outputs
  // --------------------------------------------------------------------

  // Metadata travels on without the data word
  assign rw_meta = '{
    op:        req_q.op,
    opaque:    req_q.opaque,
    origin:    req_q.origin,
    addr:      req_q.addr,
    byte_mask: req_q.byte_mask
  };

  // Reads never write any lane
  assign wr_mask = (req_q.op == MEM_OP_WRITE) ? req_q.byte_mask : 4'b0000;

  always_comb begin
    // Bank access only on the handoff cycle
    bank_cmd.rd_en     = rw_xfer;
    bank_cmd.wr_mask   = wr_mask;
    // Drop lane bits and everything above the word address
    bank_cmd.word_addr = req_q.addr[2 +: `MEM_WORD_ADDR_BITS];
    // Disabled lanes go out as zero
    for (int i = 0; i < 4; i++) begin
      bank_cmd.wdata.lane[i] = wr_mask[i] ? req_q.data.lane[i] : 8'h00;
    end
  end

endmodule

/* src/mem_resp_stage.sv */
// Memory server response stage
`timescale 1ns/1ps

module mem_resp_stage
  import mem_pkg::*;
(
  input  logic      mem_clk,
  input  logic      rst,
  // Read/write handoff from the request stage
  input  logic      rw_val,
  output logic      rw_rdy,
  input  mem_meta_t rw_meta,
  // Held read word from the banks
  input  mem_data_u bank_rdata,
  // Client response handshake
  output logic      resp_val,
  input  logic      resp_rdy,
  output mem_resp_t resp
);

  logic      valid_q;
  mem_meta_t meta_q;
  logic      rw_xfer;
  logic      resp_xfer;

  // --------------------------------------------------------------------
  // Handshakes
  // --------------------------------------------------------------------

  assign rw_xfer   = rw_val & rw_rdy;
  assign resp_xfer = valid_q & resp_rdy;

  // Open when empty, or when the client drains us this cycle
  assign rw_rdy   = !valid_q | resp_rdy;
  assign resp_val = valid_q;

  // --------------------------------------------------------------------
  // Response register
  // --------------------------------------------------------------------

  // Valid bit, a new load wins over a drain
  always_ff @(posedge mem_clk) begin
    if (rst) begin
      valid_q <= 1'b0;
    end else if (rw_xfer) begin
      valid_q <= 1'b1;
    end else if (resp_xfer) begin
      valid_q <= 1'b0;
    end
  end

  // Metadata, loaded on the same edge the banks capture the old word
  always_ff @(posedge mem_clk) begin
    if (rw_xfer) begin
      meta_q <= rw_meta;
    end
  end

  // --------------------------------------------------------------------
  // Response message
  // --------------------------------------------------------------------

  // Bank read register holds while we stall, so data needs no copy here
  assign resp = '{
    op:        meta_q.op,
    opaque:    meta_q.opaque,
    origin:    meta_q.origin,
    addr:      meta_q.addr,
    byte_mask: meta_q.byte_mask,
    data:      bank_rdata
  };

endmodule

/* src/mem_top.sv */
// On-chip memory server
`timescale 1ns/1ps

module mem_top
  import mem_pkg::*;
(
  input  logic      mem_clk,
  input  logic      rst,
  // Request channel
  input  logic      req_val,
  output logic      req_rdy,
  input  mem_req_t  req,
  // Response channel
  output logic      resp_val,
  input  logic      resp_rdy,
  output mem_resp_t resp
);

  // --------------------------------------------------------------------
  // Stage links
  // --------------------------------------------------------------------

  logic          rw_val;
  logic          rw_rdy;
  mem_meta_t     rw_meta;
  mem_bank_cmd_t bank_cmd;
  mem_data_u     bank_rdata;

  // --------------------------------------------------------------------
  // Pipeline REQ -> READ/WRITE -> RESP
  // --------------------------------------------------------------------

  // Request capture and bank command
  mem_req_stage i_req_stage (
    .mem_clk  (mem_clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .rw_val   (rw_val),
    .rw_rdy   (rw_rdy),
    .rw_meta  (rw_meta),
    .bank_cmd (bank_cmd)
  );

  // Storage
  mem_bank_array i_bank_array (
    .mem_clk    (mem_clk),
    .bank_cmd   (bank_cmd),
    .bank_rdata (bank_rdata)
  );

  // Response register
  mem_resp_stage i_resp_stage (
    .mem_clk    (mem_clk),
    .rst        (rst),
    .rw_val     (rw_val),
    .rw_rdy     (rw_rdy),
    .rw_meta    (rw_meta),
    .bank_rdata (bank_rdata),
    .resp_val   (resp_val),
    .resp_rdy   (resp_rdy),
    .resp       (resp)
  );

endmodule

/* testbench/mem_tb.sv */
// Memory server testbench
`timescale 1ns/1ps
`include "mem_cfg.svh"

module mem_tb
  import mem_pkg::*;
();

  localparam int NUM_WORDS     = 1 << `MEM_WORD_ADDR_BITS;
  localparam int REQ_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int NUM_RANDOM    = 400;
  localparam int NUM_TIMED     = 60;

  // Expected response plus bookkeeping for the compare process
  typedef struct packed {
    mem_resp_t   resp;
    logic        known;
    logic        timed;
    logic [31:0] cycle;
  } exp_entry_t;

  logic        mem_clk;
  logic        rst;
  logic        req_val;
  logic        req_rdy;
  mem_req_t    req;
  logic        resp_val;
  logic        resp_rdy;
  mem_resp_t   resp;

  integer      seed;
  integer      bp_seed;
  logic        bp_mode;
  logic        timed_mode;
  logic [31:0] cycle_cnt;
  exp_entry_t  exp_q[$];

  // Shadow memory, known marks words written in full at least once
  logic [31:0] shadow [NUM_WORDS];
  logic        shadow_known [NUM_WORDS];

  mem_top i_dut (
    .mem_clk  (mem_clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req      (req),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  bind mem_top mem_tb_sva i_sva (
    .mem_clk  (mem_clk),
    .rst      (rst),
    .req_rdy  (req_rdy),
    .req_held (i_req_stage.valid_q),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy),
    .resp     (resp)
  );

  // ------------------------------------------------------------------
  // Clock and back-pressure
  // ------------------------------------------------------------------

  initial begin
    mem_clk = 1'b0;
    forever #20 mem_clk = ~mem_clk;
  end

  // Ready about three cycles in four when back-pressure is on
  always @(posedge mem_clk) begin
    if (bp_mode) begin
      resp_rdy <= (($random(bp_seed) & 3) != 0);
    end else begin
      resp_rdy <= 1'b1;
    end
  end

  // ------------------------------------------------------------------
  // Reference model and helpers
  // ------------------------------------------------------------------

  // Metadata copied, data is the word before the access, shadow updated
  function automatic mem_resp_t ref_model(input mem_req_t r, output logic known);
    mem_resp_t   e;
    int unsigned w;
    logic [31:0] bm;
    w = (r.addr >> 2) % NUM_WORDS;
    e.op        = r.op;
    e.opaque    = r.opaque;
    e.origin    = r.origin;
    e.addr      = r.addr;
    e.byte_mask = r.byte_mask;
    e.data.word = shadow[w];
    known = shadow_known[w];
    if (r.op == MEM_OP_WRITE) begin
      bm = {{8{r.byte_mask[3]}}, {8{r.byte_mask[2]}},
            {8{r.byte_mask[1]}}, {8{r.byte_mask[0]}}};
      shadow[w] = (shadow[w] & ~bm) | (r.data.word & bm);
      if (r.byte_mask == 4'hf) begin
        shadow_known[w] = 1'b1;
      end
    end
    return e;
  endfunction

  function automatic mem_meta_t to_meta(input mem_resp_t r);
    return '{op: r.op, opaque: r.opaque, origin: r.origin,
             addr: r.addr, byte_mask: r.byte_mask};
  endfunction

  // Preload pattern, odd multiplier so every index bit matters
  function automatic logic [31:0] fill_word(input int unsigned w);
    return (w * 32'h9e37_79b9) ^ 32'h5ac3_0f96;
  endfunction

  function automatic mem_req_t make_req(input mem_op_e op, input logic [31:0] addr,
                                        input logic [3:0] mask, input logic [31:0] data,
                                        input logic [`MEM_OPAQUE_BITS-1:0] opaque);
    mem_req_t r;
    r.op        = op;
    r.opaque    = opaque;
    r.origin    = addr[5:4];
    r.addr      = addr;
    r.byte_mask = mask;
    r.data.word = data;
    return r;
  endfunction

  function automatic mem_req_t rand_req();
    mem_req_t    r;
    logic [31:0] a;
    logic [31:0] v;
    a = $random(seed);
    v = $random(seed);
    // Half the traffic hits a 64 word window through aliased addresses
    if (a[31]) begin
      a[30:8] = '0;
    end
    r.op        = v[0] ? MEM_OP_WRITE : MEM_OP_READ;
    r.opaque    = v[8 +: `MEM_OPAQUE_BITS];
    r.origin    = v[20:19];
    r.addr      = a;
    r.byte_mask = v[27:24];
    r.data.word = $random(seed);
    return r;
  endfunction

  // ------------------------------------------------------------------
  // Failure reporting and compare tasks
  // ------------------------------------------------------------------

  task automatic report_mismatch(input string msg);
    $display("ERR @%0t: %s", $time, msg);
    $display("TEST FAILED");
    $fatal(1, "stopping at first mismatch");
  endtask

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopping run");
  endtask

  task automatic check_meta(input mem_meta_t got, input mem_meta_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("meta op=%0d tag=%h org=%0d addr=%h mask=%b, want %0d %h %0d %h %b",
                                got.op, got.opaque, got.origin, got.addr, got.byte_mask,
                                exp.op, exp.opaque, exp.origin, exp.addr, exp.byte_mask));
    end
  endtask

  task automatic check_data(input mem_data_u got, input mem_data_u exp);
    if (got.word !== exp.word) begin
      report_mismatch($sformatf("data %h, expected %h", got.word, exp.word));
    end
  endtask

  // Stop at the first failed handshake assertion
  always @(posedge mem_clk) begin
    if (i_dut.i_sva.assert_fails != 0) begin
      stop_run("A handshake assertion in the bound checker failed");
    end
  end

  // ------------------------------------------------------------------
  // Compare process
  // ------------------------------------------------------------------

  // Pop before push, a response always belongs to an older request
  always @(posedge mem_clk) begin : compare
    exp_entry_t ent;
    logic       known;
    if (!rst) begin
      if (resp_val && resp_rdy) begin
        if (exp_q.size() == 0) begin
          stop_run("A response arrived with no request outstanding");
        end
        ent = exp_q.pop_front();
        check_meta(to_meta(resp), to_meta(ent.resp));
        if (ent.known) begin
          check_data(resp.data, ent.resp.data);
        end
        if (ent.timed && (cycle_cnt - ent.cycle != 32'd2)) begin
          report_mismatch($sformatf("latency %0d cycles, expected 2", cycle_cnt - ent.cycle));
        end
      end
      if (req_val && req_rdy) begin
        ent.resp  = ref_model(req, known);
        ent.known = known;
        ent.timed = timed_mode;
        ent.cycle = cycle_cnt;
        exp_q.push_back(ent);
      end
    end
    cycle_cnt = cycle_cnt + 1;
  end

  // ------------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------------

  // Hold the request until the DUT takes it
  task automatic send_req(input mem_req_t r);
    int waited;
    waited = 0;
    req_val <= 1'b1;
    req     <= r;
    do begin
      @(posedge mem_clk);
      waited++;
      if (waited > REQ_TIMEOUT) begin
        stop_run("Timeout: a request was never accepted, req_rdy stayed low");
      end
    end while (!req_rdy);
  endtask

  task automatic idle_cycles(input int n);
    req_val <= 1'b0;
    repeat (n) @(posedge mem_clk);
  endtask

  task automatic wait_drained(input string phase);
    int waited;
    waited = 0;
    req_val <= 1'b0;
    // Queue looked at between edges, after the compare process has run
    do begin
      @(negedge mem_clk);
      waited++;
      if (waited > DRAIN_TIMEOUT) begin
        stop_run({"Timeout: outstanding responses never arrived in phase ", phase});
      end
    end while (exp_q.size() != 0);
    @(posedge mem_clk);
  endtask

  initial begin : stimulus
    int i;
    int n;
    seed        = 32'hf397ae12;
    bp_seed     = ~seed;
    cycle_cnt   = '0;
    bp_mode    <= 1'b0;
    timed_mode <= 1'b0;
    rst        <= 1'b1;
    req_val    <= 1'b0;
    req        <= '0;
    resp_rdy   <= 1'b1;
    for (i = 0; i < NUM_WORDS; i++) begin
      shadow_known[i] = 1'b0;
    end
    repeat (2) @(posedge mem_clk);
    rst <= 1'b0;

    // Fill every word back to back, latency checked throughout
    timed_mode <= 1'b1;
    for (i = 0; i < NUM_WORDS; i++) begin
      send_req(make_req(MEM_OP_WRITE, i << 2, 4'hf, fill_word(i), `MEM_OPAQUE_BITS'(i)));
    end
    wait_drained("preload");

    // Full word write and read back
    send_req(make_req(MEM_OP_WRITE, 32'h0000_0040, 4'hf, 32'hdead_beef, 'h11));
    send_req(make_req(MEM_OP_READ, 32'h0000_0040, 4'hf, 32'h0, 'h12));
    // Partial masks merge into the old word
    send_req(make_req(MEM_OP_WRITE, 32'h0000_0104, 4'b0101, 32'h1122_3344, 'h21));
    send_req(make_req(MEM_OP_WRITE, 32'h0000_0104, 4'b1000, 32'haabb_ccdd, 'h22));
    send_req(make_req(MEM_OP_READ, 32'h0000_0104, 4'b0000, 32'h0, 'h23));
    // High address bits alias onto word 0x20
    send_req(make_req(MEM_OP_WRITE, 32'h8001_3080, 4'hf, 32'hcafe_f00d, 'h31));
    send_req(make_req(MEM_OP_READ, 32'h0000_0080, 4'hf, 32'h0, 'h32));
    send_req(make_req(MEM_OP_READ, 32'h0000_1080, 4'hf, 32'h0, 'h33));
    wait_drained("directed");

    // Random traffic with gaps and response back-pressure
    timed_mode <= 1'b0;
    bp_mode    <= 1'b1;
    for (i = 0; i < NUM_RANDOM; i++) begin
      n = $random(seed) & 7;
      if (n < 3) begin
        idle_cycles(n + 1);
      end
      send_req(rand_req());
    end
    wait_drained("random back-pressure");

    // Back to back with resp_rdy high, two cycle latency
    bp_mode    <= 1'b0;
    timed_mode <= 1'b1;
    for (i = 0; i < NUM_TIMED; i++) begin
      send_req(rand_req());
    end
    wait_drained("latency");

    idle_cycles(2);
    if (exp_q.size() == 0 && i_dut.i_sva.assert_fails == 0) begin
      $display("TEST OK");
    end else begin
      $display("Run ended with %0d assertion failures and %0d missing responses",
               i_dut.i_sva.assert_fails, exp_q.size());
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* testbench/mem_tb_sva.sv */
// Memory server handshake assertions
`timescale 1ns/1ps

module mem_tb_sva
  import mem_pkg::*;
(
  input logic      mem_clk,
  input logic      rst,
  input logic      req_rdy,
  // Request stage register occupied
  input logic      req_held,
  input logic      resp_val,
  input logic      resp_rdy,
  input mem_resp_t resp
);

  // Failed assertions so far
  int assert_fails = 0;

  // ------------------------------------------------------------------
  // Reset
  // ------------------------------------------------------------------

  // Response register empty right after reset
  a_resp_idle_after_rst: assert property (
    @(posedge mem_clk) rst |=> !resp_val
  ) else begin
    assert_fails++;
    $error("resp_val high in the cycle after reset");
  end

  // ------------------------------------------------------------------
  // Handshakes
  // ------------------------------------------------------------------

  // Stalled response keeps valid and payload
  a_resp_stable: assert property (
    @(posedge mem_clk) disable iff (rst)
    resp_val && !resp_rdy |=> resp_val && $stable(resp)
  ) else begin
    assert_fails++;
    $error("response changed or dropped while stalled");
  end

  // Empty request register always takes a request
  a_req_rdy_when_empty: assert property (
    @(posedge mem_clk) disable iff (rst)
    !req_held |-> req_rdy
  ) else begin
    assert_fails++;
    $error("req_rdy low with empty request register");
  end

endmodule

/* vlog.f */
+incdir+src
src/mem_pkg.sv
src/mem_req_stage.sv
src/mem_bank_array.sv
src/mem_resp_stage.sv
src/mem_top.sv
testbench/mem_tb_sva.sv
testbench/mem_tb.sv
